//--- src/print_mon_pkg.sv
/*
 * Print monitor shared definitions
 * Bus widths, snooped channel beats, arm flags and the data-word union
 */

`default_nettype none

package print_mon_pkg;

  parameter int ADDR_W = 32;  // Write address width
  parameter int DATA_W = 32;  // Write data width
  parameter int CHAR_W = 8;   // Console character width

  // Address channel beat, valid strobe only
  typedef struct packed {
    logic              valid;
    logic [ADDR_W-1:0] addr;
  } aw_beat_t;

  // Byte view of a data word
  typedef struct packed {
    logic [DATA_W-CHAR_W-1:0] pad;   // Upper bits, zero for a printable beat
    logic [CHAR_W-1:0]        bval;  // Character or exit code
  } chr_t;

  // Same data word, read whole or as a character byte
  typedef union packed {
    logic [DATA_W-1:0] word;
    chr_t              chr;
  } wdata_u;

  // Data channel beat
  typedef struct packed {
    logic   valid;
    wdata_u data;
  } w_beat_t;

  // Armed targets
  typedef struct packed {
    logic console;
    logic exit;
  } arm_t;

  // Data beat after range classification
  typedef struct packed {
    logic   valid;
    logic   in_range;  // Word value 1..255
    wdata_u data;
  } wclass_t;

endpackage

`default_nettype wire

//--- src/aw_arm_tracker.sv
/*
 * Address channel arm tracker
 * Matches address beats against the console and exit locations and holds
 * one arm flag per target until the combiner consumes it
 */

`timescale 1ns/1ps
`default_nettype none

module aw_arm_tracker #(
  parameter logic [print_mon_pkg::ADDR_W-1:0] CONSOLE_ADDR = 32'h2FFF_0004,
  parameter logic [print_mon_pkg::ADDR_W-1:0] EXIT_ADDR    = 32'h2FFF_0000
) (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  print_mon_pkg::aw_beat_t aw_i,
  input  print_mon_pkg::arm_t   consume_i,  // One-cycle clear pulses
  output print_mon_pkg::arm_t   arm_o
);

  logic                hit_console;
  logic                hit_exit;
  print_mon_pkg::arm_t arm_q;

  // Address decode, only on a valid beat
  assign hit_console = aw_i.valid && (aw_i.addr == CONSOLE_ADDR);
  assign hit_exit    = aw_i.valid && (aw_i.addr == EXIT_ADDR);

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      arm_q <= '0;  // Nothing armed
    end else begin
      // Set dominates a same-cycle consume
      if (hit_console) arm_q.console <= 1'b1;
      else if (consume_i.console) arm_q.console <= 1'b0;

      if (hit_exit) arm_q.exit <= 1'b1;
      else if (consume_i.exit) arm_q.exit <= 1'b0;
    end
  end

  assign arm_o = arm_q;  // Registered level

  // Combiner only consumes a target it saw armed
  a_consume_console_armed : assert property (
    @(posedge clk) disable iff (!rst_n_i)
    consume_i.console |-> arm_q.console
  ) else $error("Console consume without a console arm");

  a_consume_exit_armed : assert property (
    @(posedge clk) disable iff (!rst_n_i)
    consume_i.exit |-> arm_q.exit
  ) else $error("Exit consume without an exit arm");

endmodule

`default_nettype wire

//--- src/w_beat_filter.sv
/*
 * Data channel beat filter
 * Registers each data beat and tags it when the word lies in 1..255
 */

`timescale 1ns/1ps
`default_nettype none

module w_beat_filter (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  print_mon_pkg::w_beat_t w_i,
  output print_mon_pkg::wclass_t wcls_o
);

  logic                  valid_q;
  logic                  in_range_q;
  print_mon_pkg::wdata_u data_q;
  logic                  in_range;

  // Printable or exit value, whole word compared
  assign in_range = (w_i.data.word >= print_mon_pkg::DATA_W'(1)) &&
                    (w_i.data.word <= print_mon_pkg::DATA_W'(255));

  always_ff @(posedge clk) begin
    if (!rst_n_i) valid_q <= 1'b0;
    else valid_q <= w_i.valid;  // Idle cycles give valid low
  end

  // Payload, qualified by valid_q downstream
  always_ff @(posedge clk) begin
    in_range_q <= in_range;
    data_q     <= w_i.data;
  end

  assign wcls_o.valid    = valid_q;
  assign wcls_o.in_range = in_range_q;
  assign wcls_o.data     = data_q;

  // Snooped bus must carry known data on a valid beat
  a_wdata_known : assert property (
    @(posedge clk) disable iff (!rst_n_i)
    w_i.valid |-> !$isunknown(w_i.data)
  ) else $error("Unknown write data on a valid beat");

endmodule

`default_nettype wire

//--- src/char_fifo.sv
/*
 * Character FIFO
 * Circular buffer with a count; pushes into a full buffer are dropped
 * and raise a sticky overflow flag
 */

`timescale 1ns/1ps
`default_nettype none

module char_fifo #(
  parameter int FIFO_DEPTH = 4  // Power of two
) (
  input  logic                              clk,
  input  logic                              rst_n_i,
  input  logic                              push_i,
  input  logic [print_mon_pkg::CHAR_W-1:0] push_data_i,
  input  logic                              pop_i,
  output logic [print_mon_pkg::CHAR_W-1:0] head_o,
  output logic                              not_empty_o,
  output logic                              overflow_o
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  logic [print_mon_pkg::CHAR_W-1:0] mem_q [FIFO_DEPTH];
  logic [PTR_W-1:0]                  wr_ptr_q;
  logic [PTR_W-1:0]                  rd_ptr_q;
  logic [CNT_W-1:0]                  count_q;
  logic                              overflow_q;
  logic                              full;
  logic                              empty;
  logic                              do_push;
  logic                              do_pop;

  assign full    = (count_q == CNT_W'(FIFO_DEPTH));
  assign empty   = (count_q == '0);
  assign do_push = push_i && !full;   // Full means dropped, even with a pop
  assign do_pop  = pop_i && !empty;   // Pop on empty ignored

  // Storage, no reset
  always_ff @(posedge clk) begin
    if (do_push) mem_q[wr_ptr_q] <= push_data_i;
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      overflow_q <= 1'b0;
    end else begin
      if (do_push) wr_ptr_q <= wr_ptr_q + 1'b1;  // Wraps at depth
      if (do_pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;             // Both or neither
      endcase
      if (push_i && full) overflow_q <= 1'b1;   // Sticky until reset
    end
  end

  assign head_o      = mem_q[rd_ptr_q];  // Valid only while not empty
  assign not_empty_o = !empty;
  assign overflow_o  = overflow_q;

  // Occupancy bound over any push and pop sequence
  a_count_bound : assert property (
    @(posedge clk) disable iff (!rst_n_i)
    count_q <= CNT_W'(FIFO_DEPTH)
  ) else $error("FIFO count above depth");

endmodule

`default_nettype wire

//--- src/print_combiner.sv
/*
 * Print combiner
 * Matches classified data beats to armed targets, exit first, queues
 * console characters and latches the first exit code
 */

`timescale 1ns/1ps
`default_nettype none

module print_combiner #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                              clk,
  input  logic                              rst_n_i,
  input  print_mon_pkg::arm_t               arm_i,
  input  print_mon_pkg::wclass_t            wcls_i,
  input  logic                              pop_i,
  output print_mon_pkg::arm_t               consume_o,
  output logic [print_mon_pkg::CHAR_W-1:0] char_o,
  output logic                              char_valid_o,
  output logic [print_mon_pkg::CHAR_W-1:0] exit_code_o,
  output logic                              done_o,
  output logic                              overflow_o
);

  logic                              beat_hit;
  logic                              serve_exit;
  logic                              serve_console;
  logic [print_mon_pkg::CHAR_W-1:0] beat_byte;
  logic [print_mon_pkg::CHAR_W-1:0] exit_code_q;
  logic                              done_q;

  // Beats outside 1..255 leave arms untouched
  assign beat_hit      = wcls_i.valid && wcls_i.in_range;
  assign serve_exit    = beat_hit && arm_i.exit;                    // Exit wins
  assign serve_console = beat_hit && arm_i.console && !arm_i.exit;  // One target per beat
  assign beat_byte     = wcls_i.data.chr.bval;                      // Byte view of the word

  assign consume_o.exit    = serve_exit;
  assign consume_o.console = serve_console;

  // Exit code register, first exit only
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      exit_code_q <= '0;
      done_q      <= 1'b0;
    end else if (serve_exit && !done_q) begin
      exit_code_q <= beat_byte;
      done_q      <= 1'b1;  // Sticky
    end
  end

  assign exit_code_o = exit_code_q;
  assign done_o      = done_q;

  // Console characters wait here for the consumer
  char_fifo #(
    .FIFO_DEPTH ( FIFO_DEPTH )
  ) u_char_fifo (
    .clk         ( clk           ),
    .rst_n_i     ( rst_n_i       ),
    .push_i      ( serve_console ),
    .push_data_i ( beat_byte     ),
    .pop_i       ( pop_i         ),
    .head_o      ( char_o        ),
    .not_empty_o ( char_valid_o  ),
    .overflow_o  ( overflow_o    )
  );

  // At most one target served per beat
  a_consume_onehot0 : assert property (
    @(posedge clk) disable iff (!rst_n_i)
    $onehot0(consume_o)
  ) else $error("Both targets consumed by one beat");

endmodule

`default_nettype wire

//--- src/bus_print_mon.sv
/*
 * Write bus print monitor, top level
 * Snoops address and data channels of the tile's write bus and turns
 * writes to the console and exit locations into characters and an exit code
 */

`timescale 1ns/1ps
`default_nettype none

module bus_print_mon #(
  parameter logic [print_mon_pkg::ADDR_W-1:0] CONSOLE_ADDR = 32'h2FFF_0004,
  parameter logic [print_mon_pkg::ADDR_W-1:0] EXIT_ADDR    = 32'h2FFF_0000,
  parameter int                               FIFO_DEPTH   = 4  // Power of two
) (
  input  logic                              clk,
  input  logic                              rst_n_i,
  input  print_mon_pkg::aw_beat_t           aw_i,          // Snooped address beats
  input  print_mon_pkg::w_beat_t            w_i,           // Snooped data beats
  input  logic                              pop_i,         // Consumer pop strobe
  output logic [print_mon_pkg::CHAR_W-1:0] char_o,        // FIFO head
  output logic                              char_valid_o,  // FIFO not empty
  output logic [print_mon_pkg::CHAR_W-1:0] exit_code_o,
  output logic                              done_o,        // Sticky
  output logic                              overflow_o     // Sticky
);

  print_mon_pkg::arm_t    arm;      // Tracker to combiner
  print_mon_pkg::arm_t    consume;  // Combiner back to tracker
  print_mon_pkg::wclass_t wcls;     // Filter to combiner

  // Address side
  aw_arm_tracker #(
    .CONSOLE_ADDR ( CONSOLE_ADDR ),
    .EXIT_ADDR    ( EXIT_ADDR    )
  ) u_aw_arm_tracker (
    .clk       ( clk     ),
    .rst_n_i   ( rst_n_i ),
    .aw_i      ( aw_i    ),
    .consume_i ( consume ),
    .arm_o     ( arm     )
  );

  // Data side, one cycle of latency
  w_beat_filter u_w_beat_filter (
    .clk     ( clk     ),
    .rst_n_i ( rst_n_i ),
    .w_i     ( w_i     ),
    .wcls_o  ( wcls    )
  );

  // Merge point, owns the FIFO and exit registers
  print_combiner #(
    .FIFO_DEPTH ( FIFO_DEPTH )
  ) u_print_combiner (
    .clk          ( clk          ),
    .rst_n_i      ( rst_n_i      ),
    .arm_i        ( arm          ),
    .wcls_i       ( wcls         ),
    .pop_i        ( pop_i        ),
    .consume_o    ( consume      ),
    .char_o       ( char_o       ),
    .char_valid_o ( char_valid_o ),
    .exit_code_o  ( exit_code_o  ),
    .done_o       ( done_o       ),
    .overflow_o   ( overflow_o   )
  );

endmodule

`default_nettype wire

//--- sim/tb_clk_gen.sv
/*
 * Testbench clock and reset source
 * Free-running clock and an active-low reset held for a fixed number of edges
 */

`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD_NS  = 10,
  parameter int RST_CYCLES = 8
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
  end

  // Released on a rising edge, so the DUT sees a clean synchronous reset
  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

`default_nettype wire

//--- sim/print_mon_checker.sv
/*
 * Print monitor reference model and comparator
 * Follows arms, the beat pipeline, the character queue and the first exit
 */

`timescale 1ns/1ps
`default_nettype none

module print_mon_checker #(
  parameter logic [31:0] CONSOLE_ADDR = 32'h2FFF_0004,
  parameter logic [31:0] EXIT_ADDR    = 32'h2FFF_0000,
  parameter int          FIFO_DEPTH   = 4
) (
  input logic                    clk,
  input logic                    rst_n_i,
  input print_mon_pkg::aw_beat_t aw_i,
  input print_mon_pkg::w_beat_t  w_i,
  input logic                    pop_i,
  input logic [7:0]              char_i,
  input logic                    char_valid_i,
  input logic [7:0]              exit_code_i,
  input logic                    done_i,
  input logic                    overflow_i
);

  int          err_count   = 0;
  int          check_count = 0;
  string       test_name   = "none";
  logic        arm_con;     // Model arm flags
  logic        arm_exit;
  logic        pend_valid;  // Data beat of the previous edge
  logic [31:0] pend_data;
  logic [7:0]  queue [$];   // Model character FIFO
  logic        done_m;
  logic [7:0]  code_m;
  logic        ovf_m;

  task automatic start_test(input string name);
    test_name = name;
  endtask

  task automatic check_field(input string sig, input logic [31:0] exp, input logic [31:0] act);
    check_count++;
    if (act !== exp) begin
      err_count++;
      $display("Error %s: %s expected %0h actual %0h", test_name, sig, exp, act);
    end
  endtask

  // Called between edges, model and DUT both hold post-edge state
  task automatic compare_state();
    check_field("char_valid_o", queue.size() != 0, char_valid_i);
    check_field("done_o", done_m, done_i);
    check_field("exit_code_o", code_m, exit_code_i);
    check_field("overflow_o", ovf_m, overflow_i);
  endtask

  always @(posedge clk) begin : model
    logic take;
    logic push;
    logic full;
    if (!rst_n_i) begin
      arm_con    = 1'b0;
      arm_exit   = 1'b0;
      pend_valid = 1'b0;
      pend_data  = '0;
      done_m     = 1'b0;
      code_m     = '0;
      ovf_m      = 1'b0;
      queue.delete();
    end else begin
      // Accepted pop must show the oldest character
      if (pop_i) begin
        check_field("char_valid_o at pop", queue.size() != 0, char_valid_i);
        if (queue.size() != 0) check_field("char_o", queue[0], char_i);
      end
      take = pend_valid && (pend_data >= 32'd1) && (pend_data <= 32'd255);
      push = 1'b0;
      if (take && arm_exit) begin  // Exit served first
        arm_exit = 1'b0;
        if (!done_m) begin
          done_m = 1'b1;
          code_m = pend_data[7:0];  // First code stays
        end
      end else if (take && arm_con) begin
        arm_con = 1'b0;
        push    = 1'b1;
      end
      full = (queue.size() == FIFO_DEPTH);  // Occupancy before this edge
      if (push && full) ovf_m = 1'b1;
      if (pop_i && queue.size() != 0) void'(queue.pop_front());
      if (push && !full) queue.push_back(pend_data[7:0]);
      if (aw_i.valid && aw_i.addr == CONSOLE_ADDR) arm_con = 1'b1;  // Set wins
      if (aw_i.valid && aw_i.addr == EXIT_ADDR) arm_exit = 1'b1;
      pend_valid = w_i.valid;
      pend_data  = w_i.data.word;
    end
  end

endmodule

`default_nettype wire

//--- sim/tb_bus_print_mon.sv
/*
 * Testbench top for the write bus print monitor
 * Walks a table of bus writes and pops, with random gaps and filler data
 */

`timescale 1ns/1ps
`default_nettype none

module tb_bus_print_mon;

  localparam logic [31:0] CON_ADDR  = 32'h2FFF_0004;
  localparam logic [31:0] EXIT_ADDR = 32'h2FFF_0000;
  localparam logic [31:0] MISC_ADDR = 32'h1000_0000;
  localparam int          DEPTH     = 4;
  localparam int          N_TESTS   = 15;
  localparam int          ITEM_CYC  = 8;  // Worst case per write or pop
  localparam int          SETTLE    = 6;  // Drain and compare
  localparam int          K_CONSOLE = 0;
  localparam int          K_EXIT    = 1;
  localparam int          K_OTHER   = 2;
  localparam int          K_RANGE   = 3;
  localparam int          K_POP     = 4;

  logic                     clk;
  logic                     rst_n_i;
  print_mon_pkg::aw_beat_t  aw_i;
  print_mon_pkg::w_beat_t   w_i;
  logic                     pop_i;
  logic [7:0]               char_o;
  logic                     char_valid_o;
  logic [7:0]               exit_code_o;
  logic                     done_o;
  logic                     overflow_o;
  logic [31:0]              lfsr_q      = 32'ha699_ee90;
  int                       cycles      = 0;
  int                       cycle_limit = 0;
  int                       n_added     = 0;
  string                    tname [N_TESTS];  // Stimulus table columns
  int                       tkind [N_TESTS];
  logic [31:0]              taddr [N_TESTS];
  logic [31:0]              tdata [N_TESTS];
  int                       tcount [N_TESTS];

  tb_clk_gen #(.PERIOD_NS(10), .RST_CYCLES(8)) u_clk_gen (.clk_o(clk), .rst_n_o(rst_n_i));

  bus_print_mon #(.CONSOLE_ADDR(CON_ADDR), .EXIT_ADDR(EXIT_ADDR), .FIFO_DEPTH(DEPTH)) dut (.*);

  print_mon_checker #(.CONSOLE_ADDR(CON_ADDR), .EXIT_ADDR(EXIT_ADDR), .FIFO_DEPTH(DEPTH)) chk (
    .clk, .rst_n_i, .aw_i, .w_i, .pop_i,
    .char_i(char_o), .char_valid_i(char_valid_o), .exit_code_i(exit_code_o),
    .done_i(done_o), .overflow_i(overflow_o)
  );

  // Galois LFSR with taps 32, 22, 2 and 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_q = lfsr_next(lfsr_q);  // One step per bit
      v      = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  task automatic add_test(input string name, input int kind, input logic [31:0] addr,
                          input logic [31:0] data, input int count);
    tname[n_added]  = name;
    tkind[n_added]  = kind;
    taddr[n_added]  = addr;
    tdata[n_added]  = data;
    tcount[n_added] = count;
    n_added++;
  endtask

  // Address beat, then the data beat one to four edges later
  task automatic send_write(input logic [31:0] addr, input logic [31:0] data);
    int gap;
    gap = take_bits(2);
    aw_i.valid <= 1'b1;
    aw_i.addr  <= addr;
    @(posedge clk);
    aw_i.valid <= 1'b0;
    repeat (gap) @(posedge clk);
    w_i.valid     <= 1'b1;
    w_i.data.word <= data;
    @(posedge clk);
    w_i.valid     <= 1'b0;
    w_i.data.word <= take_bits(32);  // Filler on idle cycles
  endtask

  task automatic pop_char();
    while (!char_valid_o) @(posedge clk);  // Wait for a character to show
    pop_i <= 1'b1;
    @(posedge clk);
    pop_i <= 1'b0;
    @(posedge clk);
  endtask

  task automatic finish_test(input string name, input int errs_before);
    repeat (3) @(posedge clk);  // Beat reaches the outputs two edges after it
    @(negedge clk);
    chk.compare_state();
    $display("Test %s finished with %0d errors", name, chk.err_count - errs_before);
    @(posedge clk);
  endtask

  initial begin : driver
    int errs;
    int total;
    logic [31:0] data;
    aw_i  = '0;
    w_i   = '0;
    pop_i = 1'b0;
    add_test("console_abc",  K_CONSOLE, CON_ADDR,       "a",   3);
    add_test("pop_abc",      K_POP,     '0,             '0,    3);
    add_test("other_addr",   K_OTHER,   32'h2FFF_0008,  "x",   2);
    add_test("range_zero",   K_RANGE,   CON_ADDR,       '0,    1);
    add_test("range_big",    K_RANGE,   CON_ADDR,       32'h141, 2);  // Printable low byte
    add_test("standing_arm", K_OTHER,   MISC_ADDR,      "Z",   1);
    add_test("pop_z",        K_POP,     '0,             '0,    1);
    add_test("exit_first",   K_EXIT,    EXIT_ADDR,      8'h2A, 1);
    add_test("exit_second",  K_EXIT,    EXIT_ADDR,      8'h07, 1);
    add_test("console_fill", K_CONSOLE, CON_ADDR,       "A",   6);
    add_test("pop_fill",     K_POP,     '0,             '0,    4);
    add_test("arm_console",  K_RANGE,   CON_ADDR,       '0,    1);
    add_test("both_exit",    K_EXIT,    EXIT_ADDR,      8'h55, 1);
    add_test("both_console", K_OTHER,   MISC_ADDR,      "q",   1);
    add_test("pop_q",        K_POP,     '0,             '0,    1);
    total = 0;
    foreach (tcount[i]) total += tcount[i] * ITEM_CYC + SETTLE;
    cycle_limit = 2 * total + 8 + 50;  // Reset plus margin
    wait (rst_n_i);
    @(posedge clk);
    chk.start_test("after_reset");
    finish_test("after_reset", chk.err_count);
    for (int i = 0; i < N_TESTS; i++) begin
      chk.start_test(tname[i]);
      errs = chk.err_count;
      for (int r = 0; r < tcount[i]; r++) begin
        if (tkind[i] == K_POP) begin
          pop_char();
        end else if (tkind[i] == K_RANGE && tdata[i] >= 32'd256) begin
          data = tdata[i] + (take_bits(8) << 8);  // Stays at 256 or above
          send_write(taddr[i], data);
        end else begin
          send_write(taddr[i], tdata[i] + r);
        end
      end
      finish_test(tname[i], errs);
    end
    $display("Tests %0d, checks %0d, errors %0d", N_TESTS + 1, chk.check_count,
             chk.err_count);
    if (chk.err_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycle_limit != 0 && cycles >= cycle_limit) begin
      $display("Timeout: tests still running after %0d cycles", cycles);
      $display("CHECKS FAILED");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- bus_print_mon.f
src/print_mon_pkg.sv
src/aw_arm_tracker.sv
src/w_beat_filter.sv
src/char_fifo.sv
src/print_combiner.sv
src/bus_print_mon.sv
sim/tb_clk_gen.sv
sim/print_mon_checker.sv
sim/tb_bus_print_mon.sv
